//--- bench/clk_gen.sv
// free-running clock for the testbench, 4 ns period
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever #2 clk_o = ~clk_o;
	end

endmodule

`default_nettype wire

//--- bench/soc_cases.txt
# kind op addr data sel expect, all hex; op 1 is write, 2 is read
# rd and ent compare with expect, rdm with the RAM model, warm and off write the reset word
ent 2 0 0 f 7
rd 2 1 0 f 10
ent 2 2 0 f 1
rd 2 3 0 f 100
ent 2 4 0 f 0
rd 2 5 0 f 400
rd 2 6 0 f 0
rd 2 f 0 f 0
wr 1 100 11223344 f 0
wr 1 101 a5a5a5a5 f 0
wr 1 1ff cafef00d f 0
wr 1 158 0badf00d f 0
wr 1 100 000000ee 1 0
wr 1 101 5a5a0000 c 0
wr 1 1ff 00beef00 6 0
rdm 2 100 0 f 0
rdm 2 101 0 f 0
rdm 2 1ff 0 f 0
wr 1 40 ffffffff f 0
rd 2 40 0 f 0
wr 1 258 12345678 f 0
rd 2 258 0 f 0
rdm 2 158 0 f 0
ent 2 0 0 f 7
warm 1 f 2 1 0
rd 2 f 0 f 0
rdm 2 100 0 f 0
off 1 f 1 1 0
rd 2 3 0 f 100
rdm 2 1ff 0 f 0

//--- bench/tb_periph_soc.sv
// replays the cases of bench/soc_cases.txt on the pi1 bus of the peripheral fabric
// and checks reset release, warm reset and power-off on the top-level outputs
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module tb_periph_soc;

	import bus_pkg::*;
	import devmap_pkg::*;

	// cycles of sys_rst after the stretch counter is loaded with all ones
	localparam int STRETCH = (1 << `RST_CNT_BITS) - 1;

	logic clk120mhz;
	logic rst_p;
	pi1_op_e pi1_op_i;
	addr_t pi1_addr_i;
	word_t pi1_data_i;
	sel_t pi1_sel_i;
	word_t pi1_data_o;
	logic pi1_rdy_o;
	logic sys_rst_o;
	logic poweroff_o;

	string kind_q[$];
	pi1_op_e op_q[$];
	addr_t addr_q[$];
	word_t data_q[$];
	sel_t sel_q[$];
	word_t exp_q[$];
	word_t ram_model [`RAM_WORDS];
	int val_errors = 0;
	int other_errors = 0;
	bit cases_loaded = 1'b0;

	clk_gen clk_gen_i (
		.clk_o (clk120mhz)
	);

	periph_soc periph_soc_i (
		.clk120mhz  (clk120mhz),
		.rst_p      (rst_p),
		.pi1_op_i   (pi1_op_i),
		.pi1_addr_i (pi1_addr_i),
		.pi1_data_i (pi1_data_i),
		.pi1_sel_i  (pi1_sel_i),
		.pi1_data_o (pi1_data_o),
		.pi1_rdy_o  (pi1_rdy_o),
		.sys_rst_o  (sys_rst_o),
		.poweroff_o (poweroff_o)
	);

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
			val_errors++;
		end
	endtask

	task automatic check_entry(input dev_entry_u got, input dev_entry_u exp);
		if (got.entry.id !== exp.entry.id) begin
			$display("CHECK FAILED pi1_data_o.entry.id got 0x%h expected 0x%h",
				got.entry.id, exp.entry.id);
			val_errors++;
		end
		if (got.entry.useintr !== exp.entry.useintr) begin
			$display("CHECK FAILED pi1_data_o.entry.useintr got 0x%h expected 0x%h",
				got.entry.useintr, exp.entry.useintr);
			val_errors++;
		end
		if (got.entry.rsvd !== exp.entry.rsvd) begin
			$display("CHECK FAILED pi1_data_o.entry.rsvd got 0x%h expected 0x%h",
				got.entry.rsvd, exp.entry.rsvd);
			val_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
			val_errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
			val_errors++;
		end
	endtask

	// starts and ends on a falling edge and samples rdy 1 ns after each drive
	task automatic bus_access(input pi1_op_e op, input addr_t addr, input word_t data,
			input sel_t sel, output word_t rdata, output int waits);
		waits = 0;
		rdata = '0;
		pi1_op_i = op;
		pi1_addr_i = addr;
		pi1_data_i = data;
		pi1_sel_i = sel;
		#1;
		while (!pi1_rdy_o && waits < 16) begin
			@(negedge clk120mhz);
			#1;
			waits++;
		end
		if (pi1_rdy_o) begin
			rdata = pi1_data_o;
		end else begin
			$display("bus access at address 0x%h never completed", addr);
			other_errors++;
		end
		@(negedge clk120mhz);
		pi1_op_i = NOP;
	endtask

	// pulse rst_p for 2 cycles and count the cycles sys_rst stays high after it
	task automatic apply_reset(output int cycles);
		rst_p = 1'b1;
		repeat (2) @(posedge clk120mhz);
		@(negedge clk120mhz);
		rst_p = 1'b0;
		cycles = 0;
		while (sys_rst_o && cycles < 4 * STRETCH) begin
			@(negedge clk120mhz);
			cycles++;
		end
	endtask

	task automatic warm_reset_check();
		int cycles;
		cycles = 0;
		while (!sys_rst_o && cycles < 3) begin
			@(negedge clk120mhz);
			cycles++;
		end
		check_bit("sys_rst_o", sys_rst_o, 1'b1);
		cycles = 0;
		while (sys_rst_o && cycles < 4 * STRETCH) begin
			@(negedge clk120mhz);
			cycles++;
		end
		if (cycles < STRETCH) begin
			$display("warm reset held sys_rst_o for only %0d cycles", cycles);
			other_errors++;
		end
		check_bit("sys_rst_o", sys_rst_o, 1'b0);
		check_bit("poweroff_o", poweroff_o, 1'b0);
	endtask

	task automatic poweroff_check();
		int cycles;
		cycles = 0;
		while (!poweroff_o && cycles < 3) begin
			@(negedge clk120mhz);
			cycles++;
		end
		check_bit("poweroff_o", poweroff_o, 1'b1);
		// sys_rst must stay high well past any stretch
		for (cycles = 0; cycles < 2 * (STRETCH + 1) && sys_rst_o; cycles++) begin
			@(negedge clk120mhz);
		end
		check_bit("sys_rst_o", sys_rst_o, 1'b1);
		apply_reset(cycles);
		check_count("sys_rst_o cycles", cycles, STRETCH);
		check_bit("poweroff_o", poweroff_o, 1'b0);
	endtask

	task automatic run_case(input int i);
		word_t rdata;
		int idx;
		int waits;
		bit in_ram;
		idx = int'(addr_q[i]) - `RAM_BASE;
		in_ram = (idx >= 0 && idx < `RAM_WORDS);
		bus_access(op_q[i], addr_q[i], data_q[i], sel_q[i], rdata, waits);
		// the RAM inserts one wait cycle and every other target answers at once
		check_count("pi1_rdy_o wait cycles", waits, in_ram ? 1 : 0);
		// writes inside the RAM window merge into the model by byte select
		if (op_q[i] == WR && in_ram) begin
			for (int b = 0; b < `ARCH_BITS / 8; b++) begin
				if (sel_q[i][b]) begin
					ram_model[idx][8*b +: 8] = data_q[i][8*b +: 8];
				end
			end
		end
		if (kind_q[i] == "rd") begin
			check_word("pi1_data_o", rdata, exp_q[i]);
		end else if (kind_q[i] == "rdm") begin
			check_word("pi1_data_o", rdata, ram_model[idx]);
		end else if (kind_q[i] == "ent") begin
			check_entry(rdata, exp_q[i]);
		end else if (kind_q[i] == "warm") begin
			warm_reset_check();
		end else if (kind_q[i] == "off") begin
			poweroff_check();
		end else if (kind_q[i] != "wr") begin
			$display("unknown case kind %s on case %0d", kind_q[i], i);
			other_errors++;
		end
	endtask

	initial begin
		int fd;
		int n;
		int cycles;
		string line;
		string kind;
		word_t op_v;
		word_t addr_v;
		word_t data_v;
		word_t sel_v;
		word_t exp_v;
		rst_p = 1'b1;
		pi1_op_i = NOP;
		pi1_addr_i = '0;
		pi1_data_i = '0;
		pi1_sel_i = '0;
		void'($urandom(32'hf5ec_1b89));
		fd = $fopen("bench/soc_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open bench/soc_cases.txt");
			other_errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%s %h %h %h %h %h",
						kind, op_v, addr_v, data_v, sel_v, exp_v);
					if (n == 6) begin
						kind_q.push_back(kind);
						op_q.push_back(pi1_op_e'(op_v[1:0]));
						addr_q.push_back(addr_t'(addr_v));
						data_q.push_back(data_v);
						sel_q.push_back(sel_t'(sel_v));
						exp_q.push_back(exp_v);
					end
				end
			end
			$fclose(fd);
		end
		cases_loaded = 1'b1;
		apply_reset(cycles);
		check_count("sys_rst_o cycles", cycles, STRETCH);
		check_bit("poweroff_o", poweroff_o, 1'b0);
		foreach (kind_q[i]) begin
			repeat ($urandom_range(3, 0)) @(negedge clk120mhz);
			run_case(i);
		end
		$display("errors: %0d value mismatches, %0d other failures",
			val_errors, other_errors);
		if (val_errors == 0 && other_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// budget grows with the number of cases read from the file
	initial begin
		int limit;
		wait (cases_loaded);
		limit = 60 * kind_q.size() + 200;
		repeat (limit) @(posedge clk120mhz);
		$display("watchdog expired after %0d cycles, run stopped", limit);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+hw
hw/bus_pkg.sv
hw/devmap_pkg.sv
hw/reset_seq.sv
hw/bus_router.sv
hw/dev_table.sv
hw/scratch_ram.sv
hw/periph_soc.sv
bench/clk_gen.sv
bench/tb_periph_soc.sv

//--- hw/bus_pkg.sv
// types of the peripheral bus, shared by the router, the slaves and the top
// modules import this inside their body and use scoped names on their ports
`default_nettype none

`include "soc_settings.svh"

package bus_pkg;

	typedef logic [`ARCH_BITS-1:0] word_t;
	typedef logic [`ADDR_BITS-1:0] addr_t;
	typedef logic [(`ARCH_BITS/8)-1:0] sel_t;

	// bus op codes, RSVD is the swap op of the full bus and never issued here
	typedef enum logic [1:0] {
		NOP  = 2'b00,
		WR   = 2'b01,
		RD   = 2'b10,
		RSVD = 2'b11
	} pi1_op_e;

endpackage

`default_nettype wire

//--- hw/bus_router.sv
// combinational bus router for one master and the device table and RAM slaves
// unmapped accesses go to a built-in responder that completes at once with zero
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module bus_router (
	input  logic              clk120mhz,
	input  bus_pkg::pi1_op_e  m_op_i,
	input  bus_pkg::addr_t    m_addr_i,
	input  bus_pkg::word_t    m_data_i,
	input  bus_pkg::sel_t     m_sel_i,
	output bus_pkg::word_t    m_data_o,
	output logic              m_rdy_o,
	output bus_pkg::pi1_op_e  s_devtbl_op_o,
	output bus_pkg::addr_t    s_devtbl_addr_o,
	output bus_pkg::word_t    s_devtbl_data_o,
	output bus_pkg::sel_t     s_devtbl_sel_o,
	input  bus_pkg::word_t    s_devtbl_data_i,
	input  logic              s_devtbl_rdy_i,
	output bus_pkg::pi1_op_e  s_ram_op_o,
	output bus_pkg::addr_t    s_ram_addr_o,
	output bus_pkg::word_t    s_ram_data_o,
	output bus_pkg::sel_t     s_ram_sel_o,
	input  bus_pkg::word_t    s_ram_data_i,
	input  logic              s_ram_rdy_i
);

	import bus_pkg::*;
	import devmap_pkg::*;

	addr_t devtbl_off;
	addr_t ram_off;
	slave_idx_e sel_idx;

	// offsets wrap below a base, so one compare per window is enough
	assign devtbl_off = m_addr_i - addr_t'(`DEVTBL_BASE);
	assign ram_off    = m_addr_i - addr_t'(`RAM_BASE);

	always_comb begin
		if (devtbl_off < addr_t'(`DEVTBL_WORDS)) begin
			sel_idx = SLV_DEVTBL;
		end else if (ram_off < addr_t'(`RAM_WORDS)) begin
			sel_idx = SLV_RAM;
		end else begin
			sel_idx = SLV_INVALID;
		end
	end

	assign s_devtbl_addr_o = devtbl_off;
	assign s_devtbl_data_o = m_data_i;
	assign s_devtbl_sel_o  = m_sel_i;
	assign s_ram_addr_o    = ram_off;
	assign s_ram_data_o    = m_data_i;
	assign s_ram_sel_o     = m_sel_i;

	// only the selected slave sees the op, the others get NOP
	always_comb begin
		s_devtbl_op_o = NOP;
		s_ram_op_o    = NOP;
		m_data_o      = '0;
		m_rdy_o       = 1'b1;
		case (sel_idx)
			SLV_DEVTBL: begin
				s_devtbl_op_o = m_op_i;
				m_data_o      = s_devtbl_data_i;
				m_rdy_o       = s_devtbl_rdy_i;
			end
			SLV_RAM: begin
				s_ram_op_o = m_op_i;
				m_data_o   = s_ram_data_i;
				m_rdy_o    = s_ram_rdy_i;
			end
			// invalid device, zero data and immediate rdy
			default: begin
				m_data_o = '0;
				m_rdy_o  = 1'b1;
			end
		endcase
	end

	// the swap op has no slave support in this fabric
	a_no_swap: assert property (@(posedge clk120mhz) m_op_i != RSVD);

endmodule

`default_nettype wire

//--- hw/dev_table.sv
// device table slave, reports id, interrupt use and map size of each slave
// and holds the two software reset bits in the reset control word
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module dev_table (
	input  logic             clk120mhz,
	input  logic             sys_rst_i,
	input  bus_pkg::pi1_op_e op_i,
	input  bus_pkg::addr_t   addr_i,
	input  bus_pkg::word_t   data_i,
	input  bus_pkg::sel_t    sel_i,
	output bus_pkg::word_t   data_o,
	output logic             rdy_o,
	output logic             rst0_o,
	output logic             rst1_o
);

	import bus_pkg::*;
	import devmap_pkg::*;

	// two words per slave, entry first, then map size
	localparam int unsigned ENTRY_WORDS = 2 * (int'(SLV_INVALID) + 1);

	logic rst0_q;
	logic rst1_q;
	slave_idx_e slv;
	dev_entry_u ent;

	function automatic logic [15:0] id_of(slave_idx_e k);
		case (k)
			SLV_DEVTBL: return 16'(`ID_DEVTBL);
			SLV_RAM:    return 16'(`ID_RAM);
			default:    return 16'(`ID_INVALID);
		endcase
	endfunction

	function automatic word_t mapsz_of(slave_idx_e k);
		case (k)
			SLV_DEVTBL: return word_t'(`DEVTBL_WORDS);
			SLV_RAM:    return word_t'(`RAM_WORDS);
			default:    return word_t'(`INVALID_MAPSZ);
		endcase
	endfunction

	assign slv = slave_idx_e'(addr_i[2:1]);

	always_comb begin
		ent.raw = '0;
		ent.entry.id = id_of(slv);
		// no interrupt source is present, useintr stays zero
		ent.entry.useintr = 1'b0;
		if (addr_i < addr_t'(ENTRY_WORDS)) begin
			data_o = addr_i[0] ? mapsz_of(slv) : ent.raw;
		end else if (addr_i == addr_t'(`RSTCTL_WORD)) begin
			data_o = {{(`ARCH_BITS-2){1'b0}}, rst1_q, rst0_q};
		end else begin
			data_o = '0;
		end
	end

	// every access completes in the cycle it is presented
	assign rdy_o = 1'b1;

	always_ff @(posedge clk120mhz) begin
		if (sys_rst_i) begin
			rst0_q <= 1'b0;
			rst1_q <= 1'b0;
		end else if (op_i == WR && addr_i == addr_t'(`RSTCTL_WORD) && sel_i[0]) begin
			rst0_q <= data_i[0];
			rst1_q <= data_i[1];
		end
	end

	assign rst0_o = rst0_q;
	assign rst1_o = rst1_q;

endmodule

`default_nettype wire

//--- hw/devmap_pkg.sv
// slave indices of the address map and the layout of a device table entry
// used by the router for slave selection and by the device table for its words
`default_nettype none

package devmap_pkg;

	// order matches the device table, slave k owns words 2k and 2k+1
	typedef enum logic [1:0] {
		SLV_DEVTBL  = 2'd0,
		SLV_RAM     = 2'd1,
		SLV_INVALID = 2'd2
	} slave_idx_e;

	typedef struct packed {
		logic [14:0] rsvd;
		logic        useintr;
		logic [15:0] id;
	} dev_entry_s;

	// one table word, seen either as the raw bus word or as its fields
	typedef union packed {
		bus_pkg::word_t raw;
		dev_entry_s     entry;
	} dev_entry_u;

endpackage

`default_nettype wire

//--- hw/periph_soc.sv
// top of the peripheral fabric, the bus master connects to the pi1 ports
// joins the reset sequencer, the router, the device table and the RAM
`timescale 1ns/1ps
`default_nettype none

module periph_soc (
	input  logic             clk120mhz,
	input  logic             rst_p,
	input  bus_pkg::pi1_op_e pi1_op_i,
	input  bus_pkg::addr_t   pi1_addr_i,
	input  bus_pkg::word_t   pi1_data_i,
	input  bus_pkg::sel_t    pi1_sel_i,
	output bus_pkg::word_t   pi1_data_o,
	output logic             pi1_rdy_o,
	output logic             sys_rst_o,
	output logic             poweroff_o
);

	import bus_pkg::*;

	logic rst0;
	logic rst1;
	logic sys_rst;

	pi1_op_e devtbl_op;
	addr_t   devtbl_addr;
	word_t   devtbl_wdata;
	sel_t    devtbl_sel;
	word_t   devtbl_rdata;
	logic    devtbl_rdy;

	pi1_op_e ram_op;
	addr_t   ram_addr;
	word_t   ram_wdata;
	sel_t    ram_sel;
	word_t   ram_rdata;
	logic    ram_rdy;

	reset_seq reset_seq_i (
		.clk120mhz  (clk120mhz),
		.rst_p      (rst_p),
		.rst0_i     (rst0),
		.rst1_i     (rst1),
		.sys_rst_o  (sys_rst),
		.poweroff_o (poweroff_o)
	);

	bus_router bus_router_i (
		.clk120mhz       (clk120mhz),
		.m_op_i          (pi1_op_i),
		.m_addr_i        (pi1_addr_i),
		.m_data_i        (pi1_data_i),
		.m_sel_i         (pi1_sel_i),
		.m_data_o        (pi1_data_o),
		.m_rdy_o         (pi1_rdy_o),
		.s_devtbl_op_o   (devtbl_op),
		.s_devtbl_addr_o (devtbl_addr),
		.s_devtbl_data_o (devtbl_wdata),
		.s_devtbl_sel_o  (devtbl_sel),
		.s_devtbl_data_i (devtbl_rdata),
		.s_devtbl_rdy_i  (devtbl_rdy),
		.s_ram_op_o      (ram_op),
		.s_ram_addr_o    (ram_addr),
		.s_ram_data_o    (ram_wdata),
		.s_ram_sel_o     (ram_sel),
		.s_ram_data_i    (ram_rdata),
		.s_ram_rdy_i     (ram_rdy)
	);

	dev_table dev_table_i (
		.clk120mhz (clk120mhz),
		.sys_rst_i (sys_rst),
		.op_i      (devtbl_op),
		.addr_i    (devtbl_addr),
		.data_i    (devtbl_wdata),
		.sel_i     (devtbl_sel),
		.data_o    (devtbl_rdata),
		.rdy_o     (devtbl_rdy),
		.rst0_o    (rst0),
		.rst1_o    (rst1)
	);

	scratch_ram scratch_ram_i (
		.clk120mhz (clk120mhz),
		.sys_rst_i (sys_rst),
		.op_i      (ram_op),
		.addr_i    (ram_addr),
		.data_i    (ram_wdata),
		.sel_i     (ram_sel),
		.data_o    (ram_rdata),
		.rdy_o     (ram_rdy)
	);

	assign sys_rst_o = sys_rst;

endmodule

`default_nettype wire

//--- hw/reset_seq.sv
// system reset sequencer, stretches external and software resets
// and latches a software power-off until the next external reset
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module reset_seq (
	input  logic clk120mhz,
	input  logic rst_p,
	input  logic rst0_i,
	input  logic rst1_i,
	output logic sys_rst_o,
	output logic poweroff_o
);

	logic [`RST_CNT_BITS-1:0] rst_cnt;
	logic poweroff_q;
	logic sw_cold;
	logic sw_warm;
	logic sw_pwroff;

	// software requests from the device table reset bits
	assign sw_cold   = rst0_i & rst1_i;
	assign sw_warm   = ~rst0_i & rst1_i;
	assign sw_pwroff = rst0_i & ~rst1_i;

	// power-off only clears under rst_p, which already reloads the counter
	always_ff @(posedge clk120mhz) begin
		if (rst_p || sw_warm || sw_cold) begin
			rst_cnt <= '1;
		end else if (rst_cnt != '0) begin
			rst_cnt <= rst_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			poweroff_q <= 1'b0;
		end else if (sw_pwroff) begin
			poweroff_q <= 1'b1;
		end
	end

	assign sys_rst_o  = (rst_cnt != '0) || poweroff_q;
	assign poweroff_o = poweroff_q;

	// once latched, power-off keeps the system in reset until rst_p
	a_poweroff_holds: assert property (@(posedge clk120mhz) disable iff (rst_p)
		poweroff_q |=> (poweroff_q && sys_rst_o));

endmodule

`default_nettype wire

//--- hw/scratch_ram.sv
// small word RAM slave with byte selects
// each access takes one wait cycle, read data comes from a register
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module scratch_ram (
	input  logic             clk120mhz,
	input  logic             sys_rst_i,
	input  bus_pkg::pi1_op_e op_i,
	input  bus_pkg::addr_t   addr_i,
	input  bus_pkg::word_t   data_i,
	input  bus_pkg::sel_t    sel_i,
	output bus_pkg::word_t   data_o,
	output logic             rdy_o
);

	import bus_pkg::*;

	localparam int unsigned IDX_BITS = $clog2(`RAM_WORDS);

	word_t mem [`RAM_WORDS];
	word_t rd_q;
	logic wait_q;
	logic [IDX_BITS-1:0] idx;

	assign idx = addr_i[IDX_BITS-1:0];

	// low in the first cycle of a request, high in the second
	always_ff @(posedge clk120mhz) begin
		if (sys_rst_i) begin
			wait_q <= 1'b0;
		end else if (op_i != NOP) begin
			wait_q <= ~wait_q;
		end else begin
			wait_q <= 1'b0;
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (op_i == RD && !wait_q) begin
			rd_q <= mem[idx];
		end
		// write lands on the edge that ends the completing cycle
		if (op_i == WR && wait_q) begin
			for (int b = 0; b < `ARCH_BITS/8; b++) begin
				if (sel_i[b]) begin
					mem[idx][8*b +: 8] <= data_i[8*b +: 8];
				end
			end
		end
	end

	assign data_o = rd_q;
	assign rdy_o  = wait_q;

	a_wait_first: assert property (@(posedge clk120mhz) disable iff (sys_rst_i)
		(op_i != NOP) && ($past(op_i) == NOP || $past(rdy_o)) |-> !rdy_o);

endmodule

`default_nettype wire

//--- hw/soc_settings.svh
// shared widths, address map and device ids for the peripheral fabric
// include wherever a module or package needs one of these values
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// word and word-address widths of the bus
`define ARCH_BITS 32
`define ADDR_BITS 30

// width of the reset stretch counter
`define RST_CNT_BITS 4

// address map, bases and sizes in words
`define DEVTBL_BASE 0
`define DEVTBL_WORDS 16
`define RAM_BASE 256
`define RAM_WORDS 256
`define INVALID_MAPSZ 1024

// ids reported in the device table
`define ID_DEVTBL 7
`define ID_RAM 1
`define ID_INVALID 0

// device table word holding the software reset bits
`define RSTCTL_WORD 15

`endif

//--- run_sim.sh
#!/bin/sh
# run from the project root
rm -f sim.log \
	&& verilator --binary --timing --assert --top-module tb_periph_soc -f build.f -o sim \
	&& ./obj_dir/sim | tee sim.log \
	&& grep -qx '\*\* PASS \*\*' sim.log \
	|| { echo "simulation did not pass"; exit 1; }
